/* bench/rv_core_asserts.sv */
module rv_core_asserts
(
    input logic         i_clk,
    input logic         i_rst_n,
    input logic         i_cyc,
    input logic         i_stb,
    input logic         i_we,
    input logic [31:0]  i_adr,
    input logic [31:0]  i_dat,
    input logic [3:0]   i_sel,
    input logic         i_ack
);
    timeunit 1ns;
    timeprecision 100ps;

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stb |-> i_cyc)
        else $error("wishbone stb is high outside a cycle");

    // master holds the request until the slave acks
    a_hold_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stb && !i_ack) |=> ($stable(i_adr) && $stable(i_we) && $stable(i_dat)))
        else $error("wishbone request changed before ack");

    a_write_sel: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_stb && i_we) |-> (i_sel == 4'hf))
        else $error("wishbone write without all byte selects");

endmodule

bind rv_core rv_core_asserts u_wb_asserts
(
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_cyc      (o_wb_cyc),
    .i_stb      (o_wb_stb),
    .i_we       (o_wb_we),
    .i_adr      (o_wb_adr),
    .i_dat      (o_wb_dat),
    .i_sel      (o_wb_sel),
    .i_ack      (i_wb_ack)
);

/* bench/tb_rv_core.sv */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam logic [XLEN-1:0] RESET_ADDR     = 32'h0000_0000;
    localparam int              ADDR_BITS      = 16;
    localparam int              MEM_WORDS      = 1024;
    localparam int              PROG_LEN       = 200;
    localparam int              TIMEOUT_CYCLES = PROG_LEN * 12;
    localparam logic [31:0]     SEED           = 32'ha38880d1;
    localparam logic [XLEN-1:0] FINAL_ADDR     = RESET_ADDR + XLEN'(4 * (PROG_LEN - 1));
    localparam logic [XLEN-1:0] ADDR_MASK      = {{(XLEN-ADDR_BITS){1'b0}}, {ADDR_BITS{1'b1}}};

    logic               clk;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [XLEN-1:0]    wb_adr;
    logic [XLEN-1:0]    wb_dat_mosi;
    logic [3:0]         wb_sel;
    logic               wb_ack = 1'b0;
    logic [XLEN-1:0]    wb_dat_miso = '0;

    logic [31:0]        mem [MEM_WORDS];
    logic [31:0]        model_mem [MEM_WORDS];
    logic [31:0]        read_q [$];     // fetch and load addresses in bus order
    logic [31:0]        store_adr_q [$];
    logic [31:0]        store_dat_q [$];
    logic               reached_end = 1'b0;
    int                 wait_left = -1;
    int                 cycles;
    int                 seed_ret;

    rv_core
    #(
        .RESET_ADDR     (RESET_ADDR),
        .ADDR_BITS      (ADDR_BITS)
    )
    i_rv_core
    (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .o_wb_cyc       (wb_cyc),
        .o_wb_stb       (wb_stb),
        .o_wb_we        (wb_we),
        .o_wb_adr       (wb_adr),
        .o_wb_dat       (wb_dat_mosi),
        .o_wb_sel       (wb_sel),
        .i_wb_ack       (wb_ack),
        .i_wb_dat       (wb_dat_miso)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // reference result of OP and OP-IMM, sra behaves as srl in this core
    function automatic logic [31:0] compute_op(input logic [2:0] f3, input logic sub,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        int          idx;
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'h6a09e667 ^ (32'(i) * 32'h9e3779b1);
        idx = 0;
        for (int r = 1; r < 8; r++)
        begin
            mem[idx] = {20'($urandom), 5'(r), OP_LUI};
            mem[idx + 1] = i_type(12'($urandom), 5'(r), 3'b000, 5'(r), OP_IMM);
            idx += 2;
        end
        while (idx < PROG_LEN - 9)
        begin
            kind = int'($urandom_range(0, 9));
            if (kind == 9 && idx == PROG_LEN - 10)
                kind = 0;   // a jump here would skip the register dump
            rd  = 5'($urandom_range(0, 7));
            rs1 = 5'($urandom_range(0, 7));
            rs2 = ($urandom_range(0, 1) == 0) ? rs1 : 5'($urandom_range(0, 7));
            f3  = 3'($urandom_range(0, 7));
            case (kind)
                0, 1, 2, 3:
                begin
                    if (f3 == 3'b001 || f3 == 3'b011 || f3 == 3'b101)
                        f3 = 3'b000;
                    mem[idx] = i_type(12'($urandom), rs1, f3, rd, OP_IMM);
                end
                4, 5, 6:
                begin
                    if (f3 == 3'b011)
                        f3 = 3'b000;
                    f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1)
                         ? 7'b0100000 : 7'b0000000;
                    mem[idx] = r_type(f7, rs2, rs1, f3, rd);
                end
                7: mem[idx] = i_type(12'(32'h800 + 4 * $urandom_range(0, 15)), 5'd0,
                                     3'b010, rd, OP_LOAD);
                8: mem[idx] = s_type(12'(32'h800 + 4 * $urandom_range(0, 15)), rs2, 5'd0);
                default:
                    if ($urandom_range(0, 2) == 2)
                        mem[idx] = j_type(21'd8, rd);
                    else
                        mem[idx] = b_type(13'd8, rs2, rs1, 3'($urandom_range(0, 1)));
            endcase
            idx++;
        end
        for (int r = 0; r < 8; r++)
            mem[idx + r] = s_type(12'(32'h840 + 4 * r), 5'(r), 5'd0);
        mem[PROG_LEN - 1] = j_type(21'd0, 5'd0);    // spin here
        for (int i = 0; i < MEM_WORDS; i++)
            model_mem[i] = mem[i];
    endtask

    // imm 0x8xx sign-extends, so data lands at 0xf8xx and aliases on the low 12 bits
    task automatic run_model();
        logic [31:0]  x [32];
        logic [31:0]  pc;
        logic [31:0]  next_pc;
        logic [31:0]  ins;
        logic [31:0]  a;
        logic [31:0]  addr;
        logic [31:0]  imm_i;
        logic [31:0]  imm_s;
        logic [31:0]  imm_b;
        logic [31:0]  imm_j;
        for (int r = 0; r < 32; r++)
            x[r] = '0;
        pc = RESET_ADDR;
        while (pc != FINAL_ADDR)
        begin
            read_q.push_back(pc);
            ins   = model_mem[pc[11:2]];
            a     = x[ins[19:15]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            next_pc = pc + 32'd4;
            case (ins[6:0])
                OP_LUI: x[ins[11:7]] = {ins[31:12], 12'h000};
                OP_JAL:
                begin
                    x[ins[11:7]] = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                OP_BRANCH:
                    if ((ins[14:12] == 3'b000 && a == x[ins[24:20]]) ||
                        (ins[14:12] == 3'b001 && a != x[ins[24:20]]))
                        next_pc = pc + imm_b;
                OP_LOAD:
                begin
                    addr = (a + imm_i) & ADDR_MASK;
                    read_q.push_back(addr);
                    x[ins[11:7]] = model_mem[addr[11:2]];
                end
                OP_STORE:
                begin
                    addr = (a + imm_s) & ADDR_MASK;
                    store_adr_q.push_back(addr);
                    store_dat_q.push_back(x[ins[24:20]]);
                    model_mem[addr[11:2]] = x[ins[24:20]];
                end
                OP_IMM: x[ins[11:7]] = compute_op(ins[14:12], 1'b0, a, imm_i);
                OP_REG: x[ins[11:7]] = compute_op(ins[14:12], ins[30], a, x[ins[24:20]]);
                default: ;
            endcase
            x[0] = '0;
            pc = next_pc & ADDR_MASK;
        end
        read_q.push_back(FINAL_ADDR);
    endtask

    task automatic serve_transfer();
        logic [31:0] exp_adr;
        if (wb_we)
        begin
            if (store_adr_q.size() == 0)
                fail_run("the DUT wrote to memory although no store was expected");
            else
            begin
                check_value("o_wb_adr", store_adr_q.pop_front(), wb_adr);
                check_value("o_wb_dat", store_dat_q.pop_front(), wb_dat_mosi);
                check_value("o_wb_sel", 32'hf, 32'(wb_sel));
                mem[wb_adr[11:2]] = wb_dat_mosi;
            end
        end
        else if (read_q.size() == 0)
            fail_run("the DUT read from the bus after its final fetch");
        else
        begin
            exp_adr = read_q.pop_front();
            check_value("o_wb_adr", exp_adr, wb_adr);
            wb_dat_miso = mem[wb_adr[11:2]];
            if (read_q.size() == 0)
                reached_end = 1'b1;
        end
        wb_ack = 1'b1;
    endtask

    // memory slave, 0 to 3 wait states per transfer
    always @(negedge clk)
    begin
        wb_ack      = 1'b0;
        wb_dat_miso = '0;
        if (!rst_n)
        begin
            check_value("o_wb_cyc", 32'h0, 32'(wb_cyc));
            check_value("o_wb_we", 32'h0, 32'(wb_we));
        end
        else if (wb_cyc && wb_stb)
        begin
            if (wait_left < 0)
                wait_left = int'($urandom_range(0, 3));
            if (wait_left == 0)
            begin
                serve_transfer();
                wait_left = -1;
            end
            else
                wait_left--;
        end
    end

    initial
    begin
        rst_n    = 1'b0;
        seed_ret = $urandom(SEED);
        build_program();
        run_model();
        repeat (3) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (!reached_end && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!reached_end)
            fail_run($sformatf("timeout: no final fetch after %0d cycles", TIMEOUT_CYCLES));
        else if (store_adr_q.size() != 0)
            fail_run($sformatf("final fetch reached with %0d stores missing",
                               store_adr_q.size()));
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the rv_core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_rv_core \
    -f sources.f \
    -o tb_rv_core_sim

./obj_dir/tb_rv_core_sim 2>&1 | tee sim.log

# the run passes only if the testbench printed its pass line
grep -qx "TEST PASS" sim.log

/* sources.f */
verilog/rv_isa_pkg.sv
verilog/rv_core_pkg.sv
verilog/rv_decoded_if.sv
verilog/rv_decode.sv
verilog/rv_regs.sv
verilog/rv_alu.sv
verilog/rv_ctrl.sv
verilog/rv_core.sv
bench/rv_core_asserts.sv
bench/tb_rv_core.sv

/* verilog/rv_alu.sv */
module rv_alu
(
    input  rv_core_pkg::alu_op_e               i_op,
    input  logic [rv_core_pkg::XLEN-1:0]       i_a,
    input  logic [rv_core_pkg::XLEN-1:0]       i_b,
    output logic [rv_core_pkg::XLEN-1:0]       o_result,
    output logic                               o_equal
);
    import rv_core_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = i_b[SHAMT_W-1:0];

    always_comb
    begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_SLL:    o_result = i_a << shamt;
            ALU_SLT:    o_result = XLEN'($signed(i_a) < $signed(i_b));
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_SRL:    o_result = i_a >> shamt;
            ALU_OR:     o_result = i_a | i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_PASS_B: o_result = i_b;
            default:    o_result = '0;
        endcase
    end

    // beq/bne decision
    assign o_equal = (i_a == i_b);

endmodule

/* verilog/rv_core.sv */
module rv_core
#(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_ADDR = '0,
    parameter int                           ADDR_BITS  = 16
)
(
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    output logic                               o_wb_cyc,
    output logic                               o_wb_stb,
    output logic                               o_wb_we,
    output logic [rv_core_pkg::XLEN-1:0]       o_wb_adr,
    output logic [rv_core_pkg::XLEN-1:0]       o_wb_dat,
    output logic [rv_core_pkg::WB_SEL_W-1:0]   o_wb_sel,
    input  logic                               i_wb_ack,
    input  logic [rv_core_pkg::XLEN-1:0]       i_wb_dat
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [INSTR_W-1:0]     instr;
    logic [REG_ADDR_W-1:0]  rs1;
    logic [REG_ADDR_W-1:0]  rs2;
    logic [REG_ADDR_W-1:0]  rd;
    logic                   we;
    logic [XLEN-1:0]        wdata;
    logic [XLEN-1:0]        rdata1;
    logic [XLEN-1:0]        rdata2;
    alu_op_e                alu_op;
    logic [XLEN-1:0]        alu_a;
    logic [XLEN-1:0]        alu_b;
    logic [XLEN-1:0]        alu_result;
    logic                   alu_equal;

    rv_decoded_if u_dec_if ();

    rv_ctrl
    #(
        .RESET_ADDR     (RESET_ADDR),
        .ADDR_BITS      (ADDR_BITS)
    )
    u_ctrl
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .dec            (u_dec_if.ctl),
        .o_instr        (instr),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .o_rd           (rd),
        .o_we           (we),
        .o_wdata        (wdata),
        .o_alu_op       (alu_op),
        .o_alu_a        (alu_a),
        .o_alu_b        (alu_b),
        .i_alu_result   (alu_result),
        .i_alu_equal    (alu_equal),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_we        (o_wb_we),
        .o_wb_adr       (o_wb_adr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_sel       (o_wb_sel),
        .i_wb_ack       (i_wb_ack),
        .i_wb_dat       (i_wb_dat)
    );

    rv_decode
    u_decode
    (
        .i_instr        (instr),
        .dec            (u_dec_if.dec),
        .o_rs1          (rs1),
        .o_rs2          (rs2)
    );

    rv_regs
    u_regs
    (
        .i_clk          (i_clk),
        .i_rs1          (rs1),
        .i_rs2          (rs2),
        .i_rd           (rd),
        .i_we           (we),
        .i_wdata        (wdata),
        .o_rdata1       (rdata1),
        .o_rdata2       (rdata2)
    );

    rv_alu
    u_alu
    (
        .i_op           (alu_op),
        .i_a            (alu_a),
        .i_b            (alu_b),
        .o_result       (alu_result),
        .o_equal        (alu_equal)
    );

endmodule

/* verilog/rv_core_pkg.sv */
package rv_core_pkg;

    localparam int XLEN     = 32;
    localparam int WB_SEL_W = XLEN / 8;

    typedef enum logic [2:0]
    {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB
    } state_e;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* verilog/rv_ctrl.sv */
module rv_ctrl
#(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_ADDR = '0,
    parameter int                           ADDR_BITS  = 16
)
(
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    rv_decoded_if.ctl                          dec,
    output logic [rv_isa_pkg::INSTR_W-1:0]     o_instr,
    input  logic [rv_core_pkg::XLEN-1:0]       i_rdata1,
    input  logic [rv_core_pkg::XLEN-1:0]       i_rdata2,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]  o_rd,
    output logic                               o_we,
    output logic [rv_core_pkg::XLEN-1:0]       o_wdata,
    output rv_core_pkg::alu_op_e               o_alu_op,
    output logic [rv_core_pkg::XLEN-1:0]       o_alu_a,
    output logic [rv_core_pkg::XLEN-1:0]       o_alu_b,
    input  logic [rv_core_pkg::XLEN-1:0]       i_alu_result,
    input  logic                               i_alu_equal,
    output logic                               o_wb_cyc,
    output logic                               o_wb_stb,
    output logic                               o_wb_we,
    output logic [rv_core_pkg::XLEN-1:0]       o_wb_adr,
    output logic [rv_core_pkg::XLEN-1:0]       o_wb_dat,
    output logic [rv_core_pkg::WB_SEL_W-1:0]   o_wb_sel,
    input  logic                               i_wb_ack,
    input  logic [rv_core_pkg::XLEN-1:0]       i_wb_dat
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    state_e                state;
    logic                  running;     // keeps the bus idle through reset
    logic [ADDR_BITS-1:0]  pc;
    logic [ADDR_BITS-1:0]  pc_plus4;
    logic [ADDR_BITS-1:0]  pc_next;
    logic [INSTR_W-1:0]    ir;
    logic [XLEN-1:0]       load_data;
    logic                  mem_op;
    logic                  taken;

    assign mem_op   = dec.is_load | dec.is_store;
    assign taken    = dec.is_branch & ((dec.funct3 == F3_BEQ) ? i_alu_equal : !i_alu_equal);
    assign pc_plus4 = pc + ADDR_BITS'(4);
    assign pc_next  = (dec.is_jal | taken) ? pc + dec.imm[ADDR_BITS-1:0] : pc_plus4;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state   <= S_FETCH;
            running <= 1'b0;
            pc      <= RESET_ADDR[ADDR_BITS-1:0];
        end
        else
        begin
            running <= 1'b1;
            case (state)
                S_FETCH:
                    if (running && i_wb_ack)
                        state <= S_EXEC;
                S_EXEC:
                begin
                    pc    <= pc_next;
                    state <= mem_op ? S_MEM : S_FETCH;
                end
                S_MEM:
                    if (i_wb_ack)
                        state <= dec.is_load ? S_WB : S_FETCH;
                S_WB:
                    state <= S_FETCH;
                default:
                    state <= S_FETCH;
            endcase
        end
    end

    // read data is only valid while ack is high
    always_ff @(posedge i_clk)
    begin
        if (state == S_FETCH && i_wb_ack)
            ir <= i_wb_dat;
        if (state == S_MEM && i_wb_ack)
            load_data <= i_wb_dat;
    end

    assign o_instr  = ir;
    assign o_alu_op = dec.alu_op;
    assign o_alu_a  = (dec.opcode == OP_LUI) ? '0 : i_rdata1;
    assign o_alu_b  = dec.use_imm ? dec.imm : i_rdata2;

    assign o_rd = dec.rd;
    assign o_we = dec.reg_write & (((state == S_EXEC) & !dec.is_load) | (state == S_WB));

    always_comb
    begin
        if (state == S_WB)
            o_wdata = load_data;
        else if (dec.is_jal)
            o_wdata = XLEN'(pc_plus4);     // link address
        else
            o_wdata = i_alu_result;
    end

    // all bus outputs come from registers and hold until ack
    assign o_wb_cyc = running & ((state == S_FETCH) | (state == S_MEM));
    assign o_wb_stb = o_wb_cyc;
    assign o_wb_we  = (state == S_MEM) & dec.is_store;
    assign o_wb_adr = XLEN'((state == S_MEM) ? i_alu_result[ADDR_BITS-1:0] : pc);
    assign o_wb_dat = i_rdata2;
    assign o_wb_sel = '1;

endmodule

/* verilog/rv_decode.sv */
module rv_decode
(
    input  logic [rv_isa_pkg::INSTR_W-1:0]     i_instr,
    rv_decoded_if.dec                          dec,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]  o_rs1,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]  o_rs2
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e           op;
    funct3_e           f3;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_j;
    logic              valid;
    logic              writes_rd;

    // alt is instruction bit 30, only meaningful for OP
    function automatic alu_op_e alu_map(input funct3_e f, input logic alt);
        alu_op_e r;
        case (f)
            F3_ADD_SUB: r = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     r = ALU_SLL;
            F3_SLT:     r = ALU_SLT;
            F3_XOR:     r = ALU_XOR;
            F3_SRL_SRA: r = ALU_SRL;   // sra runs as srl
            F3_OR:      r = ALU_OR;
            F3_AND:     r = ALU_AND;
            default:    r = ALU_ADD;
        endcase
        return r;
    endfunction

    assign op = opcode_e'(i_instr[OPCODE_W-1:0]);
    assign f3 = funct3_e'(i_instr[14:12]);

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    assign dec.opcode = op;
    assign dec.funct3 = f3;
    assign dec.rd     = i_instr[11:7];
    assign dec.rs1    = i_instr[19:15];
    assign dec.rs2    = i_instr[24:20];
    assign o_rs1      = dec.rs1;
    assign o_rs2      = dec.rs2;

    always_comb
    begin
        dec.imm       = imm_i;
        dec.alu_op    = ALU_ADD;
        dec.use_imm   = 1'b1;
        dec.is_load   = 1'b0;
        dec.is_store  = 1'b0;
        dec.is_branch = 1'b0;
        dec.is_jal    = 1'b0;
        valid         = 1'b1;
        writes_rd     = 1'b1;
        case (op)
            OP_LUI:
                dec.imm = imm_u;           // added to a zero operand
            OP_JAL:
            begin
                dec.imm    = imm_j;
                dec.alu_op = ALU_PASS_B;
                dec.is_jal = 1'b1;
            end
            OP_BRANCH:
            begin
                dec.imm       = imm_b;
                dec.alu_op    = ALU_SUB;
                dec.use_imm   = 1'b0;
                dec.is_branch = (f3 == F3_BEQ) | (f3 == F3_BNE);
                writes_rd     = 1'b0;
            end
            OP_LOAD:
            begin
                dec.is_load = (f3 == F3_WORD);
                valid       = (f3 == F3_WORD);
            end
            OP_STORE:
            begin
                dec.imm      = imm_s;
                dec.is_store = (f3 == F3_WORD);
                writes_rd    = 1'b0;
            end
            OP_IMM:
            begin
                dec.alu_op = alu_map(f3, 1'b0);
                valid      = !(f3 inside {F3_SLL, F3_SLTU, F3_SRL_SRA});
            end
            OP_REG:
            begin
                dec.alu_op  = alu_map(f3, i_instr[30]);
                dec.use_imm = 1'b0;
                valid       = (f3 != F3_SLTU);
            end
            default:
                valid = 1'b0;              // unknown, runs as a nop
        endcase
        dec.reg_write = valid & writes_rd & (dec.rd != '0);
    end

endmodule

/* verilog/rv_decoded_if.sv */
interface rv_decoded_if;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    opcode_e                 opcode;
    funct3_e                 funct3;
    logic [REG_ADDR_W-1:0]   rd;
    logic [REG_ADDR_W-1:0]   rs1;
    logic [REG_ADDR_W-1:0]   rs2;
    logic [XLEN-1:0]         imm;
    alu_op_e                 alu_op;
    logic                    use_imm;
    logic                    reg_write;
    logic                    is_load;
    logic                    is_store;
    logic                    is_branch;
    logic                    is_jal;

    modport dec (output opcode, funct3, rd, rs1, rs2, imm, alu_op, use_imm,
                 reg_write, is_load, is_store, is_branch, is_jal);
    modport ctl (input opcode, funct3, rd, rs1, rs2, imm, alu_op, use_imm,
                 reg_write, is_load, is_store, is_branch, is_jal);

endinterface

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;

    // major opcodes, bits [6:0]
    typedef enum logic [OPCODE_W-1:0]
    {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // funct3 of OP and OP-IMM
    typedef enum logic [FUNCT3_W-1:0]
    {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    // branch and memory funct3 share the same encodings
    localparam funct3_e F3_BEQ  = F3_ADD_SUB;
    localparam funct3_e F3_BNE  = F3_SLL;
    localparam funct3_e F3_WORD = F3_SLT;

endpackage

/* verilog/rv_regs.sv */
module rv_regs
(
    input  logic                               i_clk,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  i_rs1,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  i_rs2,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  i_rd,
    input  logic                               i_we,
    input  logic [rv_core_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_core_pkg::XLEN-1:0]       o_rdata1,
    output logic [rv_core_pkg::XLEN-1:0]       o_rdata2
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge i_clk)
    begin
        if (i_we && i_rd != '0)
            regs[i_rd] <= i_wdata;
    end

    // x0 is hardwired
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule
